// ==== arithmetic_unit.sv ====
`timescale 1ns/1ps

module arithmetic_unit (
  input  vector_isa_pkg::op_t   op,
  input  vector_isa_pkg::word_t vs1,
  input  vector_isa_pkg::word_t vs2,
  input  logic                  red,   // reduction step
  output vector_isa_pkg::word_t wdata
);

  vector_isa_pkg::bit_idx_t shamt;
  vector_isa_pkg::word_t    sum;
  vector_isa_pkg::word_t    diff;
  logic                     lt;

  assign shamt = vs2[4:0];  // only low 5 bits count
  assign sum   = vs1 + vs2;
  assign diff  = vs1 - vs2;
  assign lt    = vs1 < vs2;  // unsigned compare for min/max

  always_comb begin
    if (red) begin
      // one step of a sum reduction, vs1 carries the running total
      wdata = sum;
    end else begin
      case (op)
        vector_isa_pkg::ADD: wdata = sum;
        vector_isa_pkg::SUB: wdata = diff;
        vector_isa_pkg::AND: wdata = vs1 & vs2;
        vector_isa_pkg::OR:  wdata = vs1 | vs2;
        vector_isa_pkg::XOR: wdata = vs1 ^ vs2;
        vector_isa_pkg::SLL: wdata = vs1 << shamt;
        vector_isa_pkg::SRL: wdata = vs1 >> shamt;  // logical
        vector_isa_pkg::MIN: wdata = lt ? vs1 : vs2;
        vector_isa_pkg::MAX: wdata = lt ? vs2 : vs1;
        default:             wdata = '0;  // undefined op codes
      endcase
    end
  end

endmodule

// ==== divide_unit.sv ====
`timescale 1ns/1ps

module divide_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,     // one-cycle pulse from the lane
  input  logic                  rem_sel,   // 1 = remainder, 0 = quotient
  input  vector_isa_pkg::word_t dividend,
  input  vector_isa_pkg::word_t divisor,
  output vector_isa_pkg::word_t wdata,
  output logic                  done,
  output logic                  busy,
  output logic                  div_zero
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,     // 32 shift-subtract steps
    FINISH   // result valid for one cycle
  } div_state_t;

  div_state_t               state_q;
  vector_isa_pkg::bit_idx_t count_q;  // step number inside RUN

  vector_isa_pkg::word_t rem_q;   // partial remainder
  vector_isa_pkg::word_t quo_q;   // dividend shifts out, quotient shifts in
  vector_isa_pkg::word_t dvsr_q;
  logic                  rem_sel_q;
  logic                  zero_q;   // divisor was zero at start

  logic [32:0] shifted;  // remainder with next dividend bit
  logic [32:0] trial;    // shifted minus divisor
  logic        fits;     // trial not negative

  assign shifted = {rem_q, quo_q[31]};
  assign trial   = shifted - {1'b0, dvsr_q};
  assign fits    = ~trial[32];

  // control
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= RUN;
            count_q <= '0;
          end
        end
        RUN: begin
          count_q <= count_q + 5'd1;
          if (count_q == 5'd31) state_q <= FINISH;  // last step done
        end
        FINISH:  state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // datapath, start is ignored outside IDLE
  always_ff @(posedge CLK) begin
    if (state_q == IDLE && start) begin
      rem_q     <= '0;
      quo_q     <= dividend;
      dvsr_q    <= divisor;
      rem_sel_q <= rem_sel;
      zero_q    <= (divisor == '0);
    end else if (state_q == RUN) begin
      // restoring step, keep the trial only if it fits
      rem_q <= fits ? trial[31:0] : shifted[31:0];
      quo_q <= {quo_q[30:0], fits};
    end
  end

  // zero divisor: every trial fits, so the loop itself leaves
  // all ones in the quotient and the dividend in the remainder
  assign wdata    = rem_sel_q ? rem_q : quo_q;
  assign busy     = (state_q == RUN);
  assign done     = (state_q == FINISH);
  assign div_zero = done & zero_q;  // only flagged with done

endmodule

// ==== lane_pkg.sv ====
package lane_pkg;

  // one element operation into the lane, held as a level by the driver
  typedef struct packed {
    vector_isa_pkg::fu_type_t fu_type;  // which unit
    vector_isa_pkg::op_t      op;       // per-unit op code
    vector_isa_pkg::word_t    vs1;      // accumulator for reductions, dividend
    vector_isa_pkg::word_t    vs2;      // divisor, popcount source
  } lane_req_t;

  // lane result and status, 35 bits
  typedef struct packed {
    vector_isa_pkg::word_t result;
    logic                  done;       // result is a completed element
    logic                  busy;       // divider running
    logic                  exception;  // divide by zero, with done
  } lane_out_t;

endpackage

// ==== mask_unit.sv ====
`timescale 1ns/1ps

module mask_unit (
  input  vector_isa_pkg::op_t   op,
  input  vector_isa_pkg::word_t vs1,
  input  vector_isa_pkg::word_t vs2,
  output vector_isa_pkg::word_t wdata
);

  vector_isa_pkg::word_t popc;  // set bits in vs2

  // population count, plain adder chain
  always_comb begin
    popc = '0;
    for (int i = 0; i < 32; i++) begin
      popc = popc + {31'd0, vs2[i]};
    end
  end

  // one mask bit per element
  always_comb begin
    case (op)
      vector_isa_pkg::MAND:  wdata = vs1 & vs2;
      vector_isa_pkg::MOR:   wdata = vs1 | vs2;
      vector_isa_pkg::MXOR:  wdata = vs1 ^ vs2;
      vector_isa_pkg::MANDN: wdata = vs1 & ~vs2;
      vector_isa_pkg::MPOPC: wdata = popc;
      default:               wdata = '0;
    endcase
  end

endmodule

// ==== multiply_unit.sv ====
`timescale 1ns/1ps

module multiply_unit #(
  parameter int MUL_STAGES = 2  // 1..4
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,    // issue one item this cycle
  input  vector_isa_pkg::word_t vs1,
  input  vector_isa_pkg::word_t vs2,
  output vector_isa_pkg::word_t wdata,
  output logic                  done,
  output logic                  mul_wait  // something still in flight
);

  logic [MUL_STAGES-1:0] valid_q;  // one valid bit per stage
  vector_isa_pkg::word_t a_q, b_q;  // stage 0 operands
  vector_isa_pkg::word_t prod;

  // valid chain, shifts every cycle so items can go back to back
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= start;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // operands only captured on issue
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q <= vs1;
      b_q <= vs2;
    end
  end

  assign prod = a_q * b_q;  // low 32 bits of the product

  // product stages after the operand stage
  if (MUL_STAGES == 1) begin : g_single
    assign wdata = prod;  // result straight out of stage 0
  end else begin : g_pipe
    vector_isa_pkg::word_t data_q [1:MUL_STAGES-1];

    always_ff @(posedge CLK) begin
      data_q[1] <= prod;
      for (int i = 2; i < MUL_STAGES; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign wdata = data_q[MUL_STAGES-1];
  end

  assign done = valid_q[MUL_STAGES-1];  // last stage holds a finished item

  // any item not yet at the output
  always_comb begin
    mul_wait = 1'b0;
    for (int i = 0; i < MUL_STAGES - 1; i++) begin
      mul_wait = mul_wait | valid_q[i];
    end
  end

endmodule

// ==== tb.f ====
vector_isa_pkg.sv
lane_pkg.sv
arithmetic_unit.sv
multiply_unit.sv
divide_unit.sv
mask_unit.sv
vector_lane.sv
tb_vector_lane.sv

// ==== tb_input.txt ====
// columns: fu_type op vs1 vs2 expected_result expected_exception
// fu_type 0 idle, 1 arith, 2 red, 4 div, 5 mask
1 0 00000005 00000007 0000000C 0 // add
1 0 FFFFFFFF 00000002 00000001 0 // add wraps
1 1 00000003 00000005 FFFFFFFE 0 // sub
1 2 F0F0F0F0 FF00FF00 F000F000 0 // and
1 3 F0F0F0F0 0F0F0000 FFFFF0F0 0 // or
1 4 AAAA5555 FFFF0000 55555555 0 // xor
1 5 00000001 00000024 00000010 0 // sll, low 5 bits of vs2
1 6 80000000 0000001F 00000001 0 // srl
1 7 80000000 00000001 00000001 0 // min unsigned
1 8 80000000 00000001 80000000 0 // max unsigned
2 0 00000064 00000023 00000087 0 // reduction step
2 5 FFFFFFF0 00000020 00000010 0 // reduction ignores op
0 0 00000000 00000000 00000000 0
5 0 FF00FF00 0FF00FF0 0F000F00 0 // mand
5 1 FF00FF00 0FF00FF0 FFF0FFF0 0 // mor
5 2 FF00FF00 0FF00FF0 F0F0F0F0 0 // mxor
5 3 FF00FF00 0FF00FF0 F000F000 0 // mandn
5 4 00000000 8000F00F 00000009 0 // popcount
5 4 12345678 FFFFFFFF 00000020 0
0 0 00000000 00000000 00000000 0
4 0 00000064 00000007 0000000E 0 // divu
4 1 00000064 00000007 00000002 0 // remu, back to back
0 0 00000000 00000000 00000000 0
4 0 FFFFFFFF 00000010 0FFFFFFF 0
4 1 12345678 00000100 00000078 0
0 0 00000000 00000000 00000000 0
4 0 DEADBEEF 00000000 FFFFFFFF 1 // divide by zero
4 1 DEADBEEF 00000000 DEADBEEF 1
0 0 00000000 00000000 00000000 0
1 1 00000000 00000001 FFFFFFFF 0

// ==== tb_vector_lane.sv ====
`timescale 1ns/1ps

module tb_vector_lane;

  localparam int MUL_STAGES  = 2;
  localparam int CLK_PERIOD  = 20;  // ns
  localparam int DRIVE_DELAY = 2;   // ns after the rising edge
  localparam int MAX_LINES   = 64;
  localparam int FIELDS      = 6;   // columns per line of tb_input.txt
  localparam int BURST_LEN   = 16;
  localparam int DIV_LATENCY = 33;  // request to done
  localparam int LINE_LIMIT  = 40;  // cycles allowed per file line

  logic                CLK;
  logic                nRST;
  lane_pkg::lane_req_t req;
  lane_pkg::lane_out_t lane_out;
  logic                mul_wait;

  logic [31:0]           vec_mem [0:FIELDS*MAX_LINES-1];
  int                    n_lines = 0;
  int                    run_cycles = 0;  // watchdog budget in cycles
  logic [31:0]           lfsr_q;
  vector_isa_pkg::word_t exp_q [$];  // products still in the pipeline

  vector_lane #(
    .MUL_STAGES (MUL_STAGES)
  ) i_dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .out      (lane_out),
    .mul_wait (mul_wait)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD/2) CLK = ~CLK;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // fibonacci form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_word(output logic [31:0] w);
    int i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      w      = {w[30:0], lfsr_q[0]};
    end
  endtask

  task automatic drive_req(input logic [2:0] fu, input logic [3:0] op,
                           input logic [31:0] vs1, input logic [31:0] vs2);
    @(posedge CLK);
    #(DRIVE_DELAY);
    req.fu_type = vector_isa_pkg::fu_type_t'(fu);
    req.op      = op;
    req.vs1     = vs1;
    req.vs2     = vs2;
  endtask

  // one file line with the request held until done
  task automatic replay_line(input int n);
    logic [31:0] fu, op, vs1, vs2, exp_res, exp_exc;
    int          waits;
    int          latency;
    fu      = vec_mem[FIELDS*n];
    op      = vec_mem[FIELDS*n+1];
    vs1     = vec_mem[FIELDS*n+2];
    vs2     = vec_mem[FIELDS*n+3];
    exp_res = vec_mem[FIELDS*n+4];
    exp_exc = vec_mem[FIELDS*n+5];
    drive_req(fu[2:0], op[3:0], vs1, vs2);
    @(negedge CLK);
    if (fu[2:0] == vector_isa_pkg::IDLE) begin
      // spacer leaves the lane quiet
      check_value("out.done", lane_out.done, 1'b0);
      check_value("out.busy", lane_out.busy, 1'b0);
      check_value("out.exception", lane_out.exception, 1'b0);
    end else begin
      latency = (fu[2:0] == vector_isa_pkg::DIV) ? DIV_LATENCY : 0;
      waits   = 0;
      while (!lane_out.done) begin
        check_value("out.busy", lane_out.busy, waits > 0);  // high from cycle after start
        check_value("out.exception", lane_out.exception, 1'b0);
        waits++;
        if (waits > LINE_LIMIT) begin
          stop_run($sformatf("line %0d got no done within %0d cycles", n, LINE_LIMIT));
        end
        @(negedge CLK);
      end
      check_value("out.done cycle count", waits, latency);
      check_value("out.busy", lane_out.busy, 1'b0);
      check_value("out.result", lane_out.result, exp_res);
      check_value("out.exception", lane_out.exception, exp_exc[0]);
    end
  endtask

  // back-to-back multiplies each checked MUL_STAGES edges after issue
  task automatic run_mul_burst();
    vector_isa_pkg::word_t a, b, prod;
    logic                  exp_wait;
    int                    c;
    for (c = 0; c < BURST_LEN + MUL_STAGES + 2; c++) begin
      if (c < BURST_LEN) begin
        random_word(a);
        random_word(b);
        prod = a * b;  // low word only
        exp_q.push_back(prod);
        drive_req(vector_isa_pkg::MUL, vector_isa_pkg::MUL_LO, a, b);
      end else begin
        drive_req(vector_isa_pkg::IDLE, '0, '0, '0);
      end
      @(negedge CLK);
      // in flight from the cycle after issue until the cycle before its result
      exp_wait = (MUL_STAGES > 1) && (c >= 1) && (c <= BURST_LEN + MUL_STAGES - 2);
      check_value("mul_wait", mul_wait, exp_wait);
      if (c >= MUL_STAGES && c < BURST_LEN + MUL_STAGES) begin
        check_value("out.done", lane_out.done, 1'b1);
        check_value("out.result", lane_out.result, exp_q.pop_front());
      end else begin
        check_value("out.done", lane_out.done, 1'b0);
      end
    end
  endtask

  initial begin
    nRST   = 1'b0;
    req    = '0;
    lfsr_q = 32'h9d14_4864;
    $readmemh("tb_input.txt", vec_mem);
    while (n_lines < MAX_LINES && !$isunknown(vec_mem[FIELDS*n_lines])) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      stop_run("no operations could be read from tb_input.txt");
    end
    run_cycles = LINE_LIMIT * n_lines + BURST_LEN + 100;
    repeat (4) @(posedge CLK);
    #(DRIVE_DELAY);
    nRST = 1'b1;
    @(negedge CLK);
    check_value("out.done", lane_out.done, 1'b0);
    check_value("out.busy", lane_out.busy, 1'b0);
    check_value("out.exception", lane_out.exception, 1'b0);
    check_value("mul_wait", mul_wait, 1'b0);
    for (int n = 0; n < n_lines; n++) begin
      replay_line(n);
    end
    run_mul_burst();
    $display("*** TEST PASSED ***");
    $finish;
  end

  // watchdog budget from file length and burst
  initial begin
    wait (run_cycles > 0);
    #(run_cycles * CLK_PERIOD);
    stop_run("the test ran past its time limit and was stopped by the watchdog");
  end

endmodule

// ==== vector_isa_pkg.sv ====
package vector_isa_pkg;

  // one vector element, rv32
  typedef logic [31:0] word_t;

  // shift amounts and divider step count
  typedef logic [4:0] bit_idx_t;

  // op code, meaning depends on the unit selected
  typedef logic [3:0] op_t;

  // functional unit select
  typedef enum logic [2:0] {
    IDLE  = 3'd0,  // no operation, spacer
    ARITH = 3'd1,
    RED   = 3'd2,  // reduction step, always an add
    MUL   = 3'd3,
    DIV   = 3'd4,
    MASK  = 3'd5
  } fu_type_t;

  // arithmetic unit ops
  localparam op_t ADD = 4'h0;
  localparam op_t SUB = 4'h1;
  localparam op_t AND = 4'h2;
  localparam op_t OR  = 4'h3;
  localparam op_t XOR = 4'h4;
  localparam op_t SLL = 4'h5;
  localparam op_t SRL = 4'h6;
  localparam op_t MIN = 4'h7;  // unsigned
  localparam op_t MAX = 4'h8;  // unsigned

  // multiply unit, low word only
  localparam op_t MUL_LO = 4'h0;

  // divide unit
  localparam op_t DIVU = 4'h0;
  localparam op_t REMU = 4'h1;

  // mask unit
  localparam op_t MAND  = 4'h0;
  localparam op_t MOR   = 4'h1;
  localparam op_t MXOR  = 4'h2;
  localparam op_t MANDN = 4'h3;  // vs1 and not vs2
  localparam op_t MPOPC = 4'h4;  // popcount of vs2

endpackage

// ==== vector_lane.sv ====
`timescale 1ns/1ps

module vector_lane #(
  parameter int MUL_STAGES = 2  // multiplier pipeline depth
) (
  input  logic                CLK,
  input  logic                nRST,
  input  lane_pkg::lane_req_t req,
  output lane_pkg::lane_out_t out,
  output logic                mul_wait
);

  // unit selects
  logic sel_arith, sel_red, sel_mul, sel_div, sel_mask;

  // divider start edge
  logic div_sel_q;    // DIV selected last cycle
  logic div_done_q;   // divider finished last cycle
  logic start_div;

  // unit outputs
  vector_isa_pkg::word_t wdata_a, wdata_mu, wdata_du, wdata_m;
  logic done_mu;
  logic done_du, busy_du, div_zero;

  assign sel_arith = (req.fu_type == vector_isa_pkg::ARITH);
  assign sel_red   = (req.fu_type == vector_isa_pkg::RED);
  assign sel_mul   = (req.fu_type == vector_isa_pkg::MUL);
  assign sel_div   = (req.fu_type == vector_isa_pkg::DIV);
  assign sel_mask  = (req.fu_type == vector_isa_pkg::MASK);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      div_sel_q  <= 1'b0;
      div_done_q <= 1'b0;
    end else begin
      div_sel_q  <= sel_div;
      div_done_q <= done_du;
    end
  end

  // rising edge of DIV, or DIV still held right after a finish
  assign start_div = (sel_div & ~div_sel_q) | (sel_div & div_done_q);

  arithmetic_unit u_arith (
    .op    (req.op),
    .vs1   (req.vs1),
    .vs2   (req.vs2),
    .red   (sel_red),
    .wdata (wdata_a)
  );

  multiply_unit #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mul (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (sel_mul),  // a new item every cycle MUL is held
    .vs1      (req.vs1),
    .vs2      (req.vs2),
    .wdata    (wdata_mu),
    .done     (done_mu),
    .mul_wait (mul_wait)
  );

  divide_unit u_div (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (start_div),
    .rem_sel  (req.op == vector_isa_pkg::REMU),
    .dividend (req.vs1),
    .divisor  (req.vs2),
    .wdata    (wdata_du),
    .done     (done_du),
    .busy     (busy_du),
    .div_zero (div_zero)
  );

  mask_unit u_mask (
    .op    (req.op),
    .vs1   (req.vs1),
    .vs2   (req.vs2),
    .wdata (wdata_m)
  );

  // result select, multiplier first, then divider, then the
  // combinational units
  always_comb begin
    out.result    = '0;
    out.done      = 1'b0;
    out.exception = 1'b0;
    out.busy      = busy_du;  // only the divider holds the lane busy
    if (done_mu) begin
      out.result = wdata_mu;
      out.done   = 1'b1;
    end else if (done_du) begin
      out.result    = wdata_du;
      out.done      = 1'b1;
      out.exception = div_zero;
    end else if (mul_wait) begin
      // multiplier owns the mux, arith/mask requests are dropped
      out.result = wdata_mu;
    end else if (sel_arith | sel_red) begin
      out.result = wdata_a;
      out.done   = 1'b1;
    end else if (sel_mask) begin
      out.result = wdata_m;
      out.done   = 1'b1;
    end
  end

endmodule
